//--- project.f
rtl/controlPkg.sv
rtl/functDecoder.sv
rtl/opcodeDecoder.sv
rtl/controller.sv
testbench/controllerProps_props.sv
testbench/controllerTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = controllerTb
FILELIST  = project.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
PASS_MSG  = TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- testbench/controllerTb.sv
module controllerTb;
    timeunit 1ns;
    timeprecision 1ps;
    import controlPkg::*;

    localparam int timeoutCycles = 3000;    // Tests need well under half of this

    logic        Clk;
    logic        rstN;
    instrWordT   instr;
    logic        flush;
    controlWordT ctrl;

    int    errorCount = 0;
    int    checkCount = 0;
    int    testCount = 0;
    int    cycleCount = 0;
    int    startErrors;
    int    startChecks;
    string currentTest;

    controller u_dut (
        .Clk   (Clk),
        .rstN  (rstN),
        .instr (instr),
        .flush (flush),
        .ctrl  (ctrl)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Reference decode of the R-format group
    function automatic controlWordT expectRType(instrFieldsT fl);
        controlWordT e;
        e = nopControl;
        e.regDst = dstRd;
        e.regWrite = 1'b1;
        case (fl.funct)
            fnAdd, fnAddu:   e.aluControl = aluAdd;
            fnSub:           e.aluControl = aluSub;
            fnMult, fnMultu: e.aluControl = aluMult;
            fnAnd:           e.aluControl = aluAnd;
            fnOr:            e.aluControl = aluOr;
            fnNor:           e.aluControl = aluNor;
            fnXor:           e.aluControl = aluXor;
            fnSll, fnSllv:   e.aluControl = aluSll;
            fnSra, fnSrav:   e.aluControl = aluSra;
            fnSlt:           e.aluControl = aluSlt;
            fnSltu:          e.aluControl = aluSltu;
            fnMovn:          e.aluControl = aluMovn;
            fnMovz:          e.aluControl = aluMovz;
            fnMthi:          e.aluControl = aluMthi;
            fnMtlo:          e.aluControl = aluMtlo;
            fnMfhi:          e.aluControl = aluMfhi;
            fnMflo:          e.aluControl = aluMflo;
            fnSrl: begin
                if (fl.rs[0]) e.aluControl = aluRotr;
                else e.aluControl = aluSrl;
            end
            fnSrlv: begin
                if (fl.shamt == 5'd0) e.aluControl = aluSrl;
                else if (fl.shamt == 5'd1) e.aluControl = aluRotr;
                else e.aluControl = aluNone;
            end
            default:         e.aluControl = aluNone;    // jr lands here too
        endcase
        if (fl.funct inside {fnMult, fnMultu}) e.hiLoWrite = hiLoBoth;
        if (fl.funct == fnMthi) e.hiLoWrite = hiLoHi;
        if (fl.funct == fnMtlo) e.hiLoWrite = hiLoLo;
        if (fl.funct == fnJr) e.jump = 1'b1;
        if (fl.funct inside {fnSll, fnSrl, fnSra}) begin
            e.shamtSrc = 1'b1;    // Immediate shift amount
            e.shiftImm = 1'b1;
        end
        return e;
    endfunction

    // Reference decode of everything keyed by opcode
    function automatic controlWordT expectOpcode(instrFieldsT fl);
        controlWordT e;
        e = nopControl;
        if (fl.opcode inside {opLw, opLh, opLb, opSw, opSh, opSb}) begin
            e.aluSrc = 1'b1;
            e.aluControl = aluAdd;
            if (fl.opcode inside {opLh, opSh}) e.dataType = dtHalf;
            if (fl.opcode inside {opLb, opSb}) e.dataType = dtByte;
            if (fl.opcode inside {opLw, opLh, opLb}) begin
                e.memToReg = 1'b1;
                e.regWrite = 1'b1;
                e.memRead = 1'b1;
            end else begin
                e.memWrite = 1'b1;
            end
        end else if (fl.opcode inside {opLui, opAddi, opAddiu, opAndi, opOri, opXori,
                                       opSlti, opSltiu}) begin
            e.aluSrc = 1'b1;
            e.regWrite = 1'b1;
            e.immExtSel = fl.opcode inside {opAndi, opOri, opXori};
            case (fl.opcode)
                opAddi, opAddiu: e.aluControl = aluAdd;
                opAndi:          e.aluControl = aluAnd;
                opOri:           e.aluControl = aluOr;
                opXori:          e.aluControl = aluXor;
                opSlti:          e.aluControl = aluSlt;
                opSltiu:         e.aluControl = aluSltu;
                default:         e.aluControl = aluNone;    // lui
            endcase
        end else if (fl.opcode inside {opBeq, opBne, opBgtz, opBlez, opRegImm}) begin
            e.branch = 1'b1;
            if (fl.opcode == opRegImm && fl.rt == rtBgez) e.aluControl = aluBgez;
            if (fl.opcode == opRegImm && fl.rt == rtBltz) e.aluControl = aluBltz;
        end else if (fl.opcode inside {opJ, opJal}) begin
            e.jump = 1'b1;
            e.shamtSrc = 1'b1;
            if (fl.opcode == opJal) begin
                e.regWrite = 1'b1;
                e.regDst = dstRa;
            end
        end else if (fl.opcode inside {opSpecial2, opSpecial3}) begin
            e.regDst = dstRd;
            e.regWrite = 1'b1;
            if (fl.opcode == opSpecial2 && fl.funct == fnMul) e.aluControl = aluMul;
            if (fl.opcode == opSpecial2 && fl.funct inside {fnMadd, fnMsub}) begin
                e.hiLoWrite = hiLoBoth;
                if (fl.funct == fnMadd) e.aluControl = aluMadd;
                else e.aluControl = aluMsub;
            end
            if (fl.opcode == opSpecial3 && fl.shamt == shamtSeh) e.aluControl = aluSeh;
            if (fl.opcode == opSpecial3 && fl.shamt == shamtSeb) e.aluControl = aluSeb;
        end
        return e;
    endfunction

    function automatic controlWordT expectedControl(instrWordT word, logic flushIn);
        instrFieldsT fl;
        fl = instrFieldsT'(word);
        if (flushIn) return nopControl;
        if (fl.opcode == opRType) return expectRType(fl);
        return expectOpcode(fl);
    endfunction

    function automatic instrWordT makeWord(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                           logic [4:0] shamt, logic [5:0] funct);
        return {op, rs, rt, 5'($urandom), shamt, funct};    // Random rd
    endfunction

    task automatic checkField(instrWordT word, string field, logic [4:0] got,
                              logic [4:0] want);
        assert (got === want) else begin
            $display("Mismatch ctrl.%s in %s, instr %h: got %h, expected %h",
                     field, currentTest, word, got, want);
            errorCount++;
        end
    endtask

    task automatic compareControl(instrWordT word, controlWordT want);
        checkCount++;
        checkField(word, "regDst", 5'(ctrl.regDst), 5'(want.regDst));
        checkField(word, "aluSrc", 5'(ctrl.aluSrc), 5'(want.aluSrc));
        checkField(word, "shamtSrc", 5'(ctrl.shamtSrc), 5'(want.shamtSrc));
        checkField(word, "memToReg", 5'(ctrl.memToReg), 5'(want.memToReg));
        checkField(word, "regWrite", 5'(ctrl.regWrite), 5'(want.regWrite));
        checkField(word, "hiLoWrite", 5'(ctrl.hiLoWrite), 5'(want.hiLoWrite));
        checkField(word, "memRead", 5'(ctrl.memRead), 5'(want.memRead));
        checkField(word, "memWrite", 5'(ctrl.memWrite), 5'(want.memWrite));
        checkField(word, "branch", 5'(ctrl.branch), 5'(want.branch));
        checkField(word, "jump", 5'(ctrl.jump), 5'(want.jump));
        checkField(word, "dataType", 5'(ctrl.dataType), 5'(want.dataType));
        checkField(word, "aluControl", 5'(ctrl.aluControl), 5'(want.aluControl));
        checkField(word, "immExtSel", 5'(ctrl.immExtSel), 5'(want.immExtSel));
        checkField(word, "shiftImm", 5'(ctrl.shiftImm), 5'(want.shiftImm));
    endtask

    // Drives on a falling edge and samples on the next one
    task automatic driveAndCheck(instrWordT word, logic flushIn);
        instr = word;
        flush = flushIn;
        @(negedge Clk);
        compareControl(word, expectedControl(word, flushIn));
    endtask

    task automatic markTestStart(string name);
        currentTest = name;
        startErrors = errorCount;
        startChecks = checkCount;
    endtask

    task automatic reportTest();
        testCount++;
        $display("Test %s done: %0d checks, %0d errors", currentTest,
                 checkCount - startChecks, errorCount - startErrors);
    endtask

    task automatic resetTest();
        instrWordT addWord;
        markTestStart("reset");
        addWord = makeWord(opRType, 5'd3, 5'd4, 5'd0, fnAdd);
        instr = addWord;    // Live word that reset must hide
        rstN = 1'b0;
        repeat (16) begin
            @(negedge Clk);
            compareControl(addWord, nopControl);
        end
        rstN = 1'b1;
        @(negedge Clk);
        compareControl(addWord, expectedControl(addWord, 1'b0));
        reportTest();
    endtask

    task automatic rFormatTest();
        logic [5:0] functs [$] = '{fnAdd, fnAddu, fnSub, fnMult, fnMultu, fnAnd, fnOr,
            fnNor, fnXor, fnSll, fnSllv, fnSra, fnSrav, fnSlt, fnSltu, fnMovn, fnMovz,
            fnMthi, fnMtlo, fnMfhi, fnMflo, fnJr, 6'b111111, 6'b000001};
        markTestStart("R-format");
        foreach (functs[i]) driveAndCheck(makeWord(opRType, 5'($urandom), 5'($urandom),
                                                   5'($urandom), functs[i]), 1'b0);
        driveAndCheck(makeWord(opRType, 5'b00000, 5'd7, 5'd9, fnSrl), 1'b0);
        driveAndCheck(makeWord(opRType, 5'b00001, 5'd7, 5'd9, fnSrl), 1'b0);
        driveAndCheck(makeWord(opRType, 5'b11110, 5'd7, 5'd9, fnSrl), 1'b0);
        driveAndCheck(makeWord(opRType, 5'd2, 5'd7, 5'd0, fnSrlv), 1'b0);
        driveAndCheck(makeWord(opRType, 5'd2, 5'd7, 5'd1, fnSrlv), 1'b0);
        driveAndCheck(makeWord(opRType, 5'd2, 5'd7, 5'd5, fnSrlv), 1'b0);    // Illegal shamt
        reportTest();
    endtask

    task automatic memImmJumpTest();
        logic [5:0] ops [$] = '{opLw, opLh, opLb, opSw, opSh, opSb, opLui, opAddi,
            opAddiu, opAndi, opOri, opXori, opSlti, opSltiu, opJ, opJal};
        markTestStart("memory, immediate and jump");
        foreach (ops[i]) driveAndCheck({ops[i], 26'($urandom)}, 1'b0);
        reportTest();
    endtask

    task automatic branchExtendTest();
        logic [5:0] branches [$] = '{opBeq, opBne, opBgtz, opBlez};
        logic [4:0] regImmRts [$] = '{rtBgez, rtBltz, 5'b10001};
        logic [5:0] special2 [$] = '{fnMul, fnMadd, fnMsub, 6'b000101};
        logic [4:0] special3 [$] = '{shamtSeh, shamtSeb, 5'b00000};
        markTestStart("branch and extended groups");
        foreach (branches[i]) driveAndCheck({branches[i], 26'($urandom)}, 1'b0);
        foreach (regImmRts[i]) driveAndCheck(makeWord(opRegImm, 5'd8, regImmRts[i],
                                                      5'($urandom), 6'($urandom)), 1'b0);
        foreach (special2[i]) driveAndCheck(makeWord(opSpecial2, 5'd1, 5'd2, 5'd0,
                                                     special2[i]), 1'b0);
        foreach (special3[i]) driveAndCheck(makeWord(opSpecial3, 5'd0, 5'd5, special3[i],
                                                     6'b100000), 1'b0);
        reportTest();
    endtask

    task automatic flushUnknownTest();
        logic [5:0] unused [$] = '{6'h10, 6'h11, 6'h12, 6'h18, 6'h2f, 6'h3f};
        markTestStart("flush and unknown opcodes");
        driveAndCheck(makeWord(opRType, 5'd1, 5'd2, 5'd0, fnAdd), 1'b1);
        driveAndCheck({opLw, 26'($urandom)}, 1'b1);
        driveAndCheck({opSw, 26'($urandom)}, 1'b1);
        driveAndCheck({opJal, 26'($urandom)}, 1'b1);
        driveAndCheck(makeWord(opSpecial2, 5'd1, 5'd2, 5'd0, fnMadd), 1'b1);
        foreach (unused[i]) driveAndCheck({unused[i], 26'($urandom)}, 1'b0);
        reportTest();
    endtask

    // Back to back words with one in flight per clock
    task automatic randomStreamTest();
        instrWordT word;
        markTestStart("random stream");
        for (int i = 0; i < 600; i++) begin
            word = $urandom;
            if ($urandom_range(2) == 0) word[31:26] = opRType;    // Bias toward R-format
            driveAndCheck(word, (i % 8) == 5);
        end
        reportTest();
    endtask

    initial begin
        rstN = 1'b0;
        instr = '0;
        flush = 1'b0;
        void'($urandom(32'ha854));
        resetTest();
        rFormatTest();
        memImmJumpTest();
        branchExtendTest();
        flushUnknownTest();
        randomStreamTest();
        $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount,
                 errorCount);
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- testbench/controllerProps_props.sv
module controllerProps (
    input logic                    Clk,
    input logic                    rstN,
    input logic                    flush,
    input controlPkg::controlWordT ctrl
);
    timeunit 1ns;
    timeprecision 1ps;
    import controlPkg::*;

    // A memory op either reads or writes
    memExclusive: assert property (@(posedge Clk) disable iff (!rstN)
        !(ctrl.memRead && ctrl.memWrite))
        else $error("memRead and memWrite are set together");

    loadWriteBack: assert property (@(posedge Clk) disable iff (!rstN)
        ctrl.memToReg |-> ctrl.memRead)    // Only loads return memory data
        else $error("memToReg is set without memRead");

    // Squashed slot turns into a bubble on the next edge
    bubbleAfterSquash: assert property (@(posedge Clk)
        (!rstN || flush) |=> (ctrl == nopControl))
        else $error("ctrl is not a bubble one cycle after reset or flush");

endmodule

bind controller controllerProps u_props (
    .Clk   (Clk),
    .rstN  (rstN),
    .flush (flush),
    .ctrl  (ctrl)
);

//--- rtl/controller.sv
module controller (
    input  logic                    Clk,
    input  logic                    rstN,
    input  controlPkg::instrWordT   instr,
    input  logic                    flush,
    output controlPkg::controlWordT ctrl
);
    import controlPkg::*;

    instrFieldsT fields;
    controlWordT functCtrl;
    controlWordT opcodeCtrl;
    controlWordT decodedCtrl;

    assign fields = instrFieldsT'(instr);

    // R-format decode by funct
    functDecoder u_funct (
        .fields (fields),
        .ctrl   (functCtrl)
    );

    // Everything else by opcode
    opcodeDecoder u_opcode (
        .fields (fields),
        .ctrl   (opcodeCtrl)
    );

    assign decodedCtrl = (fields.opcode == opRType) ? functCtrl : opcodeCtrl;

    // Decode/execute control register
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            ctrl <= nopControl;
        end else if (flush) begin
            ctrl <= nopControl;    // Squash into a bubble
        end else begin
            ctrl <= decodedCtrl;
        end
    end

endmodule

//--- rtl/opcodeDecoder.sv
module opcodeDecoder (
    input  controlPkg::instrFieldsT fields,
    output controlPkg::controlWordT ctrl
);
    import controlPkg::*;

    always_comb begin
        ctrl = nopControl;    // Unknown opcodes stay a bubble

        case (fields.opcode)
            // Loads
            opLw, opLh, opLb: begin
                ctrl.regDst     = dstRt;
                ctrl.aluSrc     = 1'b1;
                ctrl.memToReg   = 1'b1;
                ctrl.regWrite   = 1'b1;
                ctrl.memRead    = 1'b1;
                ctrl.aluControl = aluAdd;    // base + offset
                if (fields.opcode == opLh) begin
                    ctrl.dataType = dtHalf;
                end else if (fields.opcode == opLb) begin
                    ctrl.dataType = dtByte;
                end else begin
                    ctrl.dataType = dtWord;
                end
            end

            // Stores
            opSw, opSh, opSb: begin
                ctrl.aluSrc     = 1'b1;
                ctrl.memWrite   = 1'b1;
                ctrl.aluControl = aluAdd;
                if (fields.opcode == opSh) begin
                    ctrl.dataType = dtHalf;
                end else if (fields.opcode == opSb) begin
                    ctrl.dataType = dtByte;
                end else begin
                    ctrl.dataType = dtWord;
                end
            end

            opLui: begin
                ctrl.regDst     = dstRt;
                ctrl.aluSrc     = 1'b1;
                ctrl.regWrite   = 1'b1;
                ctrl.aluControl = aluNone;
            end

            // Immediate arithmetic and logic
            opAddi, opAddiu: begin
                ctrl.regDst     = dstRt;
                ctrl.aluSrc     = 1'b1;
                ctrl.regWrite   = 1'b1;
                ctrl.aluControl = aluAdd;
            end
            opSlti: begin
                ctrl.regDst     = dstRt;
                ctrl.aluSrc     = 1'b1;
                ctrl.regWrite   = 1'b1;
                ctrl.aluControl = aluSlt;
            end
            opSltiu: begin
                ctrl.regDst     = dstRt;
                ctrl.aluSrc     = 1'b1;
                ctrl.regWrite   = 1'b1;
                ctrl.aluControl = aluSltu;
            end
            opAndi, opOri, opXori: begin
                ctrl.regDst    = dstRt;
                ctrl.aluSrc    = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.immExtSel = 1'b1;    // Logic ops take the immediate unsigned
                case (fields.opcode)
                    opAndi:  ctrl.aluControl = aluAnd;
                    opOri:   ctrl.aluControl = aluOr;
                    default: ctrl.aluControl = aluXor;
                endcase
            end

            // Branches compare in the branch unit
            opBeq, opBne, opBgtz, opBlez: begin
                ctrl.branch     = 1'b1;
                ctrl.aluControl = aluNone;
            end
            opRegImm: begin
                ctrl.branch = 1'b1;
                case (fields.rt)
                    rtBgez:  ctrl.aluControl = aluBgez;
                    rtBltz:  ctrl.aluControl = aluBltz;
                    default: ctrl.aluControl = aluNone;
                endcase
            end

            opJ: begin
                ctrl.jump       = 1'b1;
                ctrl.shamtSrc   = 1'b1;
                ctrl.aluControl = aluNone;
            end
            opJal: begin
                ctrl.jump       = 1'b1;
                ctrl.shamtSrc   = 1'b1;
                ctrl.regWrite   = 1'b1;
                ctrl.regDst     = dstRa;    // Return address into r31
                ctrl.aluControl = aluNone;
            end

            // Multiply group
            opSpecial2: begin
                ctrl.regDst   = dstRd;
                ctrl.regWrite = 1'b1;
                case (fields.funct)
                    fnMul: begin
                        ctrl.aluControl = aluMul;
                    end
                    fnMadd: begin
                        ctrl.aluControl = aluMadd;
                        ctrl.hiLoWrite  = hiLoBoth;
                    end
                    fnMsub: begin
                        ctrl.aluControl = aluMsub;
                        ctrl.hiLoWrite  = hiLoBoth;
                    end
                    default: begin
                        ctrl.aluControl = aluNone;
                    end
                endcase
            end

            // Sign extension
            opSpecial3: begin
                ctrl.regDst   = dstRd;
                ctrl.regWrite = 1'b1;
                case (fields.shamt)
                    shamtSeh: ctrl.aluControl = aluSeh;
                    shamtSeb: ctrl.aluControl = aluSeb;
                    default:  ctrl.aluControl = aluNone;
                endcase
            end

            default: begin
                ctrl = nopControl;
            end
        endcase
    end

endmodule

//--- rtl/functDecoder.sv
module functDecoder (
    input  controlPkg::instrFieldsT fields,
    output controlPkg::controlWordT ctrl
);
    import controlPkg::*;

    always_comb begin
        // R-format group flags
        ctrl            = nopControl;
        ctrl.regDst     = dstRd;
        ctrl.regWrite   = 1'b1;

        case (fields.funct)
            fnAdd, fnAddu: begin
                ctrl.aluControl = aluAdd;
            end
            fnSub: begin
                ctrl.aluControl = aluSub;
            end
            fnMult, fnMultu: begin
                ctrl.aluControl = aluMult;
                ctrl.hiLoWrite  = hiLoBoth;    // 64-bit product
            end
            fnAnd: begin
                ctrl.aluControl = aluAnd;
            end
            fnOr: begin
                ctrl.aluControl = aluOr;
            end
            fnNor: begin
                ctrl.aluControl = aluNor;
            end
            fnXor: begin
                ctrl.aluControl = aluXor;
            end
            fnSll: begin
                ctrl.aluControl = aluSll;
                ctrl.shamtSrc   = 1'b1;
                ctrl.shiftImm   = 1'b1;
            end
            fnSllv: begin
                ctrl.aluControl = aluSll;
            end
            fnSrl: begin
                // Bit 21 set means rotr
                if (fields.rs[0]) begin
                    ctrl.aluControl = aluRotr;
                end else begin
                    ctrl.aluControl = aluSrl;
                end
                ctrl.shamtSrc = 1'b1;
                ctrl.shiftImm = 1'b1;
            end
            fnSrlv: begin
                case (fields.shamt)
                    shamtSrlv:  ctrl.aluControl = aluSrl;
                    shamtRotrv: ctrl.aluControl = aluRotr;
                    default:    ctrl.aluControl = aluNone;  // Reserved encoding
                endcase
            end
            fnSra: begin
                ctrl.aluControl = aluSra;
                ctrl.shamtSrc   = 1'b1;
                ctrl.shiftImm   = 1'b1;
            end
            fnSrav: begin
                ctrl.aluControl = aluSra;
            end
            fnSlt: begin
                ctrl.aluControl = aluSlt;
            end
            fnSltu: begin
                ctrl.aluControl = aluSltu;
            end
            fnMovn: begin
                ctrl.aluControl = aluMovn;
            end
            fnMovz: begin
                ctrl.aluControl = aluMovz;
            end
            fnMthi: begin
                ctrl.aluControl = aluMthi;
                ctrl.hiLoWrite  = hiLoHi;
            end
            fnMtlo: begin
                ctrl.aluControl = aluMtlo;
                ctrl.hiLoWrite  = hiLoLo;
            end
            fnMfhi: begin
                ctrl.aluControl = aluMfhi;
            end
            fnMflo: begin
                ctrl.aluControl = aluMflo;
            end
            fnJr: begin
                ctrl.jump       = 1'b1;    // Target comes from rs
                ctrl.aluControl = aluNone;
            end
            default: begin
                ctrl.aluControl = aluNone;
            end
        endcase
    end

endmodule

//--- rtl/controlPkg.sv
package controlPkg;

    typedef logic [31:0] instrWordT;

    // Field view of a 32-bit instruction word, MSB first
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;     // Bit 21 doubles as rotate select
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instrFieldsT;

    typedef enum logic [1:0] {
        dstRt = 2'd0,
        dstRd = 2'd1,
        dstRa = 2'd2    // Link register for jal
    } regDstT;

    typedef enum logic [1:0] {
        hiLoNone = 2'd0,
        hiLoHi   = 2'd1,
        hiLoLo   = 2'd2,
        hiLoBoth = 2'd3
    } hiLoWriteT;

    typedef enum logic [1:0] {
        dtWord = 2'd0,
        dtHalf = 2'd1,
        dtByte = 2'd2
    } dataTypeT;

    // Codes must match the ALU
    typedef enum logic [4:0] {
        aluAdd  = 5'd0,  aluSub  = 5'd1,  aluMult = 5'd2,  aluAnd  = 5'd3,
        aluOr   = 5'd4,  aluNor  = 5'd5,  aluXor  = 5'd6,  aluSll  = 5'd7,
        aluSrl  = 5'd8,  aluRotr = 5'd9,  aluSlt  = 5'd10, aluMovn = 5'd11,
        aluMovz = 5'd12, aluSra  = 5'd13, aluSltu = 5'd14, aluMthi = 5'd15,
        aluMtlo = 5'd16, aluMfhi = 5'd17, aluMflo = 5'd18, aluMul  = 5'd19,
        aluMadd = 5'd20, aluMsub = 5'd21, aluSeh  = 5'd22, aluSeb  = 5'd23,
        aluBgez = 5'd24, aluBltz = 5'd25, aluNone = 5'd31
    } aluOpT;

    typedef struct packed {
        regDstT    regDst;
        logic      aluSrc;      // Immediate as second operand
        logic      shamtSrc;    // Second-source select for shifts and jumps
        logic      memToReg;
        logic      regWrite;
        hiLoWriteT hiLoWrite;
        logic      memRead;
        logic      memWrite;
        logic      branch;
        logic      jump;
        dataTypeT  dataType;
        aluOpT     aluControl;
        logic      immExtSel;   // andi, ori, xori only
        logic      shiftImm;    // Shift amount taken from shamt
    } controlWordT;

    // Bubble, nothing written and no ALU work
    localparam controlWordT nopControl = '{
        regDst: dstRt, aluSrc: 1'b0, shamtSrc: 1'b0, memToReg: 1'b0,
        regWrite: 1'b0, hiLoWrite: hiLoNone, memRead: 1'b0, memWrite: 1'b0,
        branch: 1'b0, jump: 1'b0, dataType: dtWord, aluControl: aluNone,
        immExtSel: 1'b0, shiftImm: 1'b0
    };

    localparam logic [5:0] opRType    = 6'b000000;
    localparam logic [5:0] opRegImm   = 6'b000001;  // bgez, bltz
    localparam logic [5:0] opSpecial2 = 6'b011100;  // mul, madd, msub
    localparam logic [5:0] opSpecial3 = 6'b011111;  // seh, seb
    localparam logic [5:0] opLw    = 6'b100011, opLh  = 6'b100001, opLb   = 6'b100000;
    localparam logic [5:0] opSw    = 6'b101011, opSh  = 6'b101001, opSb   = 6'b101000;
    localparam logic [5:0] opLui   = 6'b001111;
    localparam logic [5:0] opBeq   = 6'b000100, opBne = 6'b000101;
    localparam logic [5:0] opBgtz  = 6'b000111, opBlez = 6'b000110;
    localparam logic [5:0] opAddi  = 6'b001000, opAddiu = 6'b001001;
    localparam logic [5:0] opAndi  = 6'b001100, opOri = 6'b001101, opXori = 6'b001110;
    localparam logic [5:0] opSlti  = 6'b001010, opSltiu = 6'b001011;
    localparam logic [5:0] opJ     = 6'b000010, opJal = 6'b000011;

    localparam logic [5:0] fnAdd  = 6'b100000, fnAddu  = 6'b100001, fnSub  = 6'b100010;
    localparam logic [5:0] fnMult = 6'b011000, fnMultu = 6'b011001;
    localparam logic [5:0] fnAnd  = 6'b100100, fnOr    = 6'b100101;
    localparam logic [5:0] fnNor  = 6'b100111, fnXor   = 6'b100110;
    localparam logic [5:0] fnSll  = 6'b000000, fnSllv  = 6'b000100;
    localparam logic [5:0] fnSrl  = 6'b000010;  // Also rotr
    localparam logic [5:0] fnSrlv = 6'b000110;  // Also rotrv
    localparam logic [5:0] fnSra  = 6'b000011, fnSrav  = 6'b000111;
    localparam logic [5:0] fnSlt  = 6'b101010, fnSltu  = 6'b101011;
    localparam logic [5:0] fnMovn = 6'b001011, fnMovz  = 6'b001010;
    localparam logic [5:0] fnMthi = 6'b010001, fnMtlo  = 6'b010011;
    localparam logic [5:0] fnMfhi = 6'b010000, fnMflo  = 6'b010010;
    localparam logic [5:0] fnJr   = 6'b001000;

    // Special2 group functs
    localparam logic [5:0] fnMul  = 6'b000010, fnMadd = 6'b000000, fnMsub = 6'b000100;

    // Sub-fields
    localparam logic [4:0] shamtSrlv  = 5'b00000;
    localparam logic [4:0] shamtRotrv = 5'b00001;
    localparam logic [4:0] shamtSeh   = 5'b11000;
    localparam logic [4:0] shamtSeb   = 5'b10000;
    localparam logic [4:0] rtBgez     = 5'b00001;
    localparam logic [4:0] rtBltz     = 5'b00000;

endpackage
